//--- run.sh
#!/usr/bin/env bash
# Build the scene loader testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module tb_scene_loader \
  -f vlog.f \
  -o sim_tb_scene_loader

output=$(./obj_dir/sim_tb_scene_loader)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi

//--- source/link_pkg.sv
package link_pkg;

  // Command byte sent ahead of each payload.
  // Slot bits 1..0 pick a camera vector, bits 3..0 an object.
  typedef struct packed {
    logic       is_cam;
    logic [2:0] unused;
    logic [3:0] slot;
  } cmd_t;

  // Wishbone byte address of one 32-bit word.
  typedef struct packed {
    logic       region;
    logic [5:0] entry;
    logic [1:0] word;
  } wb_addr_t;

  // Region encodings.
  localparam logic REGION_CAM = 1'b0;
  localparam logic REGION_OBJ = 1'b1;

  // Words per entry in the address map.
  localparam int WORDS_PER_ENTRY = 4;

endpackage

//--- source/load_frame_assembler.sv
`timescale 1ns/1ps

module load_frame_assembler (
  input  logic              clk,
  input  logic              rst,
  input  logic              byte_valid,
  input  logic [7:0]        byte_data,
  output logic              cam_we,
  output logic [1:0]        cam_waddr,
  output scene_pkg::vec3_t  cam_wdata,
  output logic              obj_we,
  output logic [3:0]        obj_waddr,
  output scene_pkg::obj_t   obj_wdata
);
  import scene_pkg::*;
  import link_pkg::*;

  localparam int PAY_W = OBJ_BYTES * 8;
  localparam int VEC_W = VEC_BYTES * 8;
  localparam int CNT_W = $clog2(OBJ_BYTES);
  localparam logic [CNT_W-1:0] CAM_LAST = CNT_W'(VEC_BYTES - 1);
  localparam logic [CNT_W-1:0] OBJ_LAST = CNT_W'(OBJ_BYTES - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CAM,
    ST_OBJ
  } state_t;

  state_t           state;
  cmd_t             cmd;
  cam_slot_t        cam_slot;
  logic [3:0]       obj_slot;
  logic [CNT_W-1:0] byte_cnt;
  logic [PAY_W-1:0] payload_q;

  assign cmd = cmd_t'(byte_data);

  // One shift register serves both payloads.
  // A camera vector ends up in the top bits.
  assign cam_wdata = payload_q[PAY_W-1 -: VEC_W];
  assign obj_wdata = payload_q;
  assign cam_waddr = cam_slot;
  assign obj_waddr = obj_slot;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      cam_slot <= CAM_ORIGIN;
      obj_slot <= '0;
      byte_cnt <= '0;
      cam_we   <= 1'b0;
      obj_we   <= 1'b0;
    end else begin
      cam_we <= 1'b0;
      obj_we <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (byte_valid) begin
            byte_cnt <= '0;
            if (cmd.is_cam) begin
              cam_slot <= cam_slot_t'(cmd.slot[1:0]);
              state    <= ST_CAM;
            end else begin
              obj_slot <= cmd.slot;
              state    <= ST_OBJ;
            end
          end
        end
        ST_CAM, ST_OBJ: begin
          if (byte_valid) begin
            // LSB first on the line, so new bytes enter at the top.
            payload_q <= {byte_data, payload_q[PAY_W-1:8]};
            if (state == ST_CAM && byte_cnt == CAM_LAST) begin
              cam_we <= 1'b1;
              state  <= ST_IDLE;
            end else if (state == ST_OBJ && byte_cnt == OBJ_LAST) begin
              obj_we <= 1'b1;
              state  <= ST_IDLE;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Only one store is written at a time.
  a_we_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(cam_we && obj_we)
  ) else $error("cam_we and obj_we high together");

endmodule

//--- source/scene_cfg.svh
`ifndef SCENE_CFG_SVH
`define SCENE_CFG_SVH

// Scene store depths.
`define SCENE_OBJ_COUNT 16
`define SCENE_CAM_COUNT 4

// Serial bit period in clock cycles.
// Kept short for simulation.
`define UART_CLKS_PER_BIT 8

// Width of the Wishbone data bus.
`define WB_DATA_WIDTH 32

`endif

//--- source/scene_loader_top.sv
`timescale 1ns/1ps
`include "scene_cfg.svh"

module scene_loader_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      rx,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  link_pkg::wb_addr_t        adr,
  input  logic [`WB_DATA_WIDTH-1:0] dat_w,
  output logic [`WB_DATA_WIDTH-1:0] dat_r,
  output logic                      ack
);
  import scene_pkg::*;

  localparam int CAM_AW = $clog2(`SCENE_CAM_COUNT);
  localparam int OBJ_AW = $clog2(`SCENE_OBJ_COUNT);

  logic              byte_valid;
  logic [7:0]        byte_data;
  logic              cam_we;
  logic [CAM_AW-1:0] cam_waddr;
  vec3_t             cam_wdata;
  logic [CAM_AW-1:0] cam_raddr;
  vec3_t             cam_rdata;
  logic              obj_we;
  logic [OBJ_AW-1:0] obj_waddr;
  obj_t              obj_wdata;
  logic [OBJ_AW-1:0] obj_raddr;
  obj_t              obj_rdata;

  uart_byte_rx u_rx (
    .clk(clk), .rst(rst), .rx(rx),
    .byte_valid(byte_valid), .byte_data(byte_data)
  );

  load_frame_assembler u_assembler (
    .clk(clk), .rst(rst),
    .byte_valid(byte_valid), .byte_data(byte_data),
    .cam_we(cam_we), .cam_waddr(cam_waddr), .cam_wdata(cam_wdata),
    .obj_we(obj_we), .obj_waddr(obj_waddr), .obj_wdata(obj_wdata)
  );

  scene_store #(.payload_t(vec3_t), .DEPTH(`SCENE_CAM_COUNT)) cam_store (
    .clk(clk), .rst(rst),
    .we(cam_we), .waddr(cam_waddr), .wdata(cam_wdata),
    .raddr(cam_raddr), .rdata(cam_rdata)
  );

  scene_store #(.payload_t(obj_t), .DEPTH(`SCENE_OBJ_COUNT)) obj_store (
    .clk(clk), .rst(rst),
    .we(obj_we), .waddr(obj_waddr), .wdata(obj_wdata),
    .raddr(obj_raddr), .rdata(obj_rdata)
  );

  scene_wb_port u_wb_port (
    .clk(clk), .rst(rst),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
    .cam_raddr(cam_raddr), .cam_rdata(cam_rdata),
    .obj_raddr(obj_raddr), .obj_rdata(obj_rdata)
  );

endmodule

//--- source/scene_pkg.sv
package scene_pkg;

  // Signed fixed-point coordinate.
  typedef logic signed [23:0] coord_t;

  // Three coordinates, x in the lowest bits.
  typedef struct packed {
    coord_t z;
    coord_t y;
    coord_t x;
  } vec3_t;

  // 8-bit channels, blue lowest.
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // Sphere record, center in the lowest bits.
  typedef struct packed {
    rgb_t   color;
    coord_t radius;
    vec3_t  center;
  } obj_t;

  // Camera vector slots.
  typedef enum logic [1:0] {
    CAM_ORIGIN  = 2'd0,
    CAM_RIGHT   = 2'd1,
    CAM_FORWARD = 2'd2,
    CAM_UP      = 2'd3
  } cam_slot_t;

  // Payload sizes on the serial line.
  localparam int VEC_BYTES = $bits(vec3_t) / 8;
  localparam int OBJ_BYTES = $bits(obj_t) / 8;

endpackage

//--- source/scene_store.sv
`timescale 1ns/1ps

module scene_store #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  payload_t                 wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output payload_t                 rdata
);

  payload_t mem [DEPTH];

  // Every entry starts out as zero.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read with one cycle of latency.
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

  a_waddr_range: assert property (
    @(posedge clk) disable iff (rst) we |-> (waddr < DEPTH)
  ) else $error("write address %0d out of range", waddr);

endmodule

//--- source/scene_wb_port.sv
`timescale 1ns/1ps
`include "scene_cfg.svh"

module scene_wb_port (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  link_pkg::wb_addr_t        adr,
  input  logic [`WB_DATA_WIDTH-1:0] dat_w,
  output logic [`WB_DATA_WIDTH-1:0] dat_r,
  output logic                      ack,
  output logic [1:0]                cam_raddr,
  input  scene_pkg::vec3_t          cam_rdata,
  output logic [3:0]                obj_raddr,
  input  scene_pkg::obj_t           obj_rdata
);
  import scene_pkg::*;
  import link_pkg::*;

  localparam int WORD_W = `WB_DATA_WIDTH;
  localparam int LINE_W = WORDS_PER_ENTRY * WORD_W;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_ADDR,
    BUS_DATA
  } step_t;

  step_t             step;
  wb_addr_t          adr_q;
  logic              we_q;
  logic              entry_ok;
  logic [LINE_W-1:0] line_sel;
  logic [WORD_W-1:0] word_sel;

  // Pick the entry and the word from the store outputs.
  always_comb begin
    line_sel = '0;
    entry_ok = 1'b0;
    case (adr_q.region)
      REGION_CAM: begin
        line_sel = {{(LINE_W - $bits(vec3_t)){1'b0}}, cam_rdata};
        entry_ok = adr_q.entry < 6'(`SCENE_CAM_COUNT);
      end
      REGION_OBJ: begin
        line_sel = {{(LINE_W - $bits(obj_t)){1'b0}}, obj_rdata};
        entry_ok = adr_q.entry < 6'(`SCENE_OBJ_COUNT);
      end
    endcase
    word_sel = (entry_ok && !we_q) ? line_sel[adr_q.word * WORD_W +: WORD_W] : '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      step <= BUS_IDLE;
      ack  <= 1'b0;
    end else begin
      ack <= 1'b0;
      case (step)
        BUS_IDLE: begin
          // The cycle holding ack still shows stb, so it is skipped.
          if (cyc && stb && !ack) begin
            adr_q     <= adr;
            we_q      <= we;
            cam_raddr <= adr.entry[1:0];
            obj_raddr <= adr.entry[3:0];
            step      <= BUS_ADDR;
          end
        end
        BUS_ADDR: step <= BUS_DATA;
        BUS_DATA: begin
          dat_r <= word_sel;
          ack   <= 1'b1;
          step  <= BUS_IDLE;
        end
        default: step <= BUS_IDLE;
      endcase
    end
  end

  a_ack_pulse: assert property (
    @(posedge clk) disable iff (rst) ack |=> !ack
  ) else $error("ack high on two consecutive cycles");

  // Master holds the request until it sees ack.
  a_request_held: assert property (
    @(posedge clk) disable iff (rst)
    (cyc && stb && !ack) |=>
      ack || (cyc && stb && $stable(adr) && $stable(we) && $stable(dat_w))
  ) else $error("bus request changed before ack");

endmodule

//--- source/uart_byte_rx.sv
`timescale 1ns/1ps
`include "scene_cfg.svh"

module uart_byte_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,
  output logic       byte_valid,
  output logic [7:0] byte_data
);
  localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             start_edge;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;

  // Two-flop synchronizer plus one stage for edge detection.
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev & ~rx_sync;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= RX_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (start_edge) begin
            clk_cnt <= '0;
            state   <= RX_START;
          end
        end
        RX_START: begin
          // Check the start bit again at its middle.
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            shift   <= {rx_sync, shift[7:1]};
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          // Low stop bit means a framing error, so no strobe.
          if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            state   <= RX_IDLE;
            if (rx_sync) begin
              byte_valid <= 1'b1;
              byte_data  <= shift;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

//--- testbench/tb_scene_loader.sv
`timescale 1ns/1ps
`include "scene_cfg.svh"

module tb_scene_loader;
  import link_pkg::*;

  localparam int CPB = `UART_CLKS_PER_BIT;
  // Frames sent: 40 camera, 64 object, 26 overwrite, 11 framing.
  localparam int NUM_FRAMES = 141;
  // Six full scans of 80 words plus 8 bus writes.
  localparam int NUM_BUS = 6 * 80 + 8;
  localparam int TIMEOUT = (NUM_FRAMES * 10 * CPB + NUM_BUS * 4) * 2;

  logic        clk = 1'b0;
  logic        rst;
  logic        rx;
  logic        cyc;
  logic        stb;
  logic        we;
  wb_addr_t    adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;

  // Expected scene contents.
  logic [71:0]  cam_model [4];
  logic [119:0] obj_model [16];

  integer seed = 37;
  int errors = 0;
  int checks = 0;
  int tests_failed = 0;
  int cycle_count = 0;

  scene_loader_top UUT (
    .clk(clk), .rst(rst), .rx(rx),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic rand_vec(output logic [71:0] v);
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    v = r[71:0];
  endtask

  task automatic rand_obj(output logic [119:0] o);
    logic [127:0] r;
    r = {$random(seed), $random(seed), $random(seed), $random(seed)};
    o = r[119:0];
  endtask

  // 32-bit word of an entry, lowest word first, zero above the payload.
  function automatic logic [31:0] expected_word(input logic region, input int entry,
                                                input int word);
    logic [127:0] line;
    line = '0;
    if (region) begin
      line[119:0] = obj_model[entry];
    end else begin
      line[71:0] = cam_model[entry];
    end
    return line[word*32 +: 32];
  endfunction

  // Start bit, data LSB first, stop bit, then one idle bit.
  task automatic send_byte(input logic [7:0] b, input logic bad_stop);
    logic [10:0] frame;
    frame = {1'b1, ~bad_stop, b, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 11; i++) begin
      rx <= frame[i];
      repeat (CPB) @(posedge clk);
    end
  endtask

  task automatic send_vec(input logic [1:0] slot, input logic [2:0] extra,
                          input logic [71:0] v);
    send_byte({1'b1, extra, 2'b00, slot}, 1'b0);
    for (int i = 0; i < 9; i++) begin
      send_byte(v[i*8 +: 8], 1'b0);
    end
    cam_model[slot] = v;
  endtask

  task automatic send_obj(input logic [3:0] slot, input logic [2:0] extra,
                          input logic [119:0] o);
    send_byte({1'b0, extra, slot}, 1'b0);
    for (int i = 0; i < 15; i++) begin
      send_byte(o[i*8 +: 8], 1'b0);
    end
    obj_model[slot] = o;
  endtask

  // One classic cycle. lat counts falling edges from the drive edge to ack.
  task automatic wb_access(input logic wr, input logic [8:0] a, input logic [31:0] wd,
                           output logic [31:0] rd, output int lat);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= wd;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!ack);
    rd = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [8:0] a, output logic [31:0] rd, output int lat);
    wb_access(1'b0, a, 32'h0, rd, lat);
  endtask

  task automatic wb_write(input logic [8:0] a, input logic [31:0] wd, output int lat);
    logic [31:0] unused_rd;
    wb_access(1'b1, a, wd, unused_rd, lat);
  endtask

  // The slave sees the request one edge after the drive edge.
  task automatic check_latency(input int lat);
    checks++;
    assert (lat - 2 == 2) else begin
      $display("ack came %0d clocks after the request was seen instead of 2", lat - 2);
      errors++;
    end
  endtask

  task automatic check_word(input logic region, input int entry, input int word);
    logic [31:0] got;
    logic [31:0] exp;
    int lat;
    exp = expected_word(region, entry, word);
    wb_read({region, 6'(entry), 2'(word)}, got, lat);
    checks++;
    assert (got == exp) else begin
      $display("Fail: dat_r region %0d entry %0d word %0d expected %h got %h",
               region, entry, word, exp, got);
      errors++;
    end
    check_latency(lat);
  endtask

  task automatic check_all();
    for (int e = 0; e < 4; e++) begin
      for (int w = 0; w < 4; w++) begin
        check_word(1'b0, e, w);
      end
    end
    for (int e = 0; e < 16; e++) begin
      for (int w = 0; w < 4; w++) begin
        check_word(1'b1, e, w);
      end
    end
  endtask

  task automatic test_reset_state();
    check_all();
  endtask

  task automatic test_camera_load();
    logic [71:0] v;
    for (int s = 0; s < 4; s++) begin
      rand_vec(v);
      send_vec(2'(s), 3'b000, v);
    end
    check_all();
  endtask

  // Slots 0, 5, 10 and 15; the rest stay zero.
  task automatic test_object_load();
    logic [119:0] o;
    for (int i = 0; i < 4; i++) begin
      rand_obj(o);
      send_obj(4'(i * 5), 3'b000, o);
    end
    check_all();
  endtask

  task automatic test_overwrite();
    logic [71:0]  v;
    logic [119:0] o;
    logic [31:0]  r;
    r = $random(seed);
    rand_vec(v);
    send_vec(2'd1, r[2:0], v);
    rand_obj(o);
    send_obj(4'd5, r[6:4], o);
    check_all();
  endtask

  // A junk byte with a low stop bit sits between payload bytes 3 and 4.
  task automatic test_framing_error();
    logic [71:0] v;
    logic [31:0] r;
    r = $random(seed);
    rand_vec(v);
    send_byte({1'b1, 3'b000, 2'b00, 2'd2}, 1'b0);
    for (int i = 0; i < 9; i++) begin
      if (i == 4) begin
        send_byte(r[7:0], 1'b1);
      end
      send_byte(v[i*8 +: 8], 1'b0);
    end
    cam_model[2] = v;
    check_all();
  endtask

  task automatic test_bus_write();
    logic [31:0] r;
    logic        region;
    int          entry;
    int          lat;
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      region = i[0];
      entry = region ? i * 2 + 1 : i / 2;
      wb_write({region, 6'(entry), 2'(i % 4)}, r, lat);
      check_latency(lat);
    end
    check_all();
  endtask

  task automatic finish_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - start_errors);
      tests_failed++;
    end
  endtask

  initial begin
    int start;
    rst   = 1'b1;
    rx    = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    for (int i = 0; i < 4; i++) begin
      cam_model[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
      obj_model[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    start = errors;
    test_reset_state();
    finish_test("reset state", start);
    start = errors;
    test_camera_load();
    finish_test("camera load", start);
    start = errors;
    test_object_load();
    finish_test("object load", start);
    start = errors;
    test_overwrite();
    finish_test("overwrite and isolation", start);
    start = errors;
    test_framing_error();
    finish_test("framing error", start);
    start = errors;
    test_bus_write();
    finish_test("bus writes", start);

    $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+source
source/scene_pkg.sv
source/link_pkg.sv
source/uart_byte_rx.sv
source/load_frame_assembler.sv
source/scene_store.sv
source/scene_wb_port.sv
source/scene_loader_top.sv
testbench/tb_scene_loader.sv
